/* source/riscv_decode_pkg.sv */
package riscv_decode_pkg;

	localparam int INSTR_W      = 32;
	localparam int PC_W_DEFAULT = 64;
	localparam int REG_IDX_W    = 5;
	localparam int SHAMT_W      = 6;
	localparam int ALU_OP_W     = 5;

	// major opcodes, instr[6:0]
	localparam logic [6:0] OPC_LUI       = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
	localparam logic [6:0] OPC_JAL       = 7'b1101111;
	localparam logic [6:0] OPC_JALR      = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
	localparam logic [6:0] OPC_LOAD      = 7'b0000011;
	localparam logic [6:0] OPC_STORE     = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_32     = 7'b0111011;
	localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

	// only ecall is accepted under SYSTEM
	localparam logic [INSTR_W-1:0] ECALL_WORD = 32'h0000_0073;

	localparam logic [ALU_OP_W-1:0] ALU_NONE   = 5'd0;
	localparam logic [ALU_OP_W-1:0] ALU_ADD    = 5'd1;
	localparam logic [ALU_OP_W-1:0] ALU_SUB    = 5'd2;
	localparam logic [ALU_OP_W-1:0] ALU_SLL    = 5'd3;
	localparam logic [ALU_OP_W-1:0] ALU_SRL    = 5'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SRA    = 5'd5;
	localparam logic [ALU_OP_W-1:0] ALU_XOR    = 5'd6;
	localparam logic [ALU_OP_W-1:0] ALU_OR     = 5'd7;
	localparam logic [ALU_OP_W-1:0] ALU_AND    = 5'd8;
	localparam logic [ALU_OP_W-1:0] ALU_LESS   = 5'd9;
	localparam logic [ALU_OP_W-1:0] ALU_LESSU  = 5'd10;
	localparam logic [ALU_OP_W-1:0] ALU_EQUAL  = 5'd11;
	localparam logic [ALU_OP_W-1:0] ALU_NEQ    = 5'd12;
	localparam logic [ALU_OP_W-1:0] ALU_GTE    = 5'd13;
	localparam logic [ALU_OP_W-1:0] ALU_GTEU   = 5'd14;
	localparam logic [ALU_OP_W-1:0] ALU_MUL    = 5'd15;
	localparam logic [ALU_OP_W-1:0] ALU_MULH   = 5'd16;
	localparam logic [ALU_OP_W-1:0] ALU_MULHSU = 5'd17;
	localparam logic [ALU_OP_W-1:0] ALU_MULHU  = 5'd18;
	localparam logic [ALU_OP_W-1:0] ALU_DIV    = 5'd19;
	localparam logic [ALU_OP_W-1:0] ALU_DIVU   = 5'd20;
	localparam logic [ALU_OP_W-1:0] ALU_REM    = 5'd21;
	localparam logic [ALU_OP_W-1:0] ALU_REMU   = 5'd22;
	localparam logic [ALU_OP_W-1:0] ALU_JUMP   = 5'd23;
	localparam logic [ALU_OP_W-1:0] ALU_IMMVAL = 5'd24;

	localparam logic [2:0] FMT_NONE = 3'd0;
	localparam logic [2:0] FMT_R    = 3'd1;
	localparam logic [2:0] FMT_I    = 3'd2;
	localparam logic [2:0] FMT_S    = 3'd3;
	localparam logic [2:0] FMT_SB   = 3'd4;
	localparam logic [2:0] FMT_U    = 3'd5;
	localparam logic [2:0] FMT_UJ   = 3'd6;

	localparam logic [1:0] MEM_NONE  = 2'd0;
	localparam logic [1:0] MEM_READ  = 2'd1;
	localparam logic [1:0] MEM_WRITE = 2'd2;

	// the U sizes are the zero-extending loads
	localparam logic [2:0] SIZE_NONE   = 3'd0;
	localparam logic [2:0] SIZE_BYTE   = 3'd1;
	localparam logic [2:0] SIZE_HALF   = 3'd2;
	localparam logic [2:0] SIZE_WORD   = 3'd3;
	localparam logic [2:0] SIZE_DOUBLE = 3'd4;
	localparam logic [2:0] SIZE_UBYTE  = 3'd5;
	localparam logic [2:0] SIZE_UHALF  = 3'd6;
	localparam logic [2:0] SIZE_UWORD  = 3'd7;

	localparam logic [1:0] BR_NONE    = 2'd0;
	localparam logic [1:0] BR_COND    = 2'd1;
	localparam logic [1:0] BR_UNCOND  = 2'd2;

	// one view per encoding format, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_view_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_view_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_view_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_view_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_view_t;

	typedef union packed {
		r_view_t r;
		i_view_t i;
		s_view_t s;
		b_view_t b;
		u_view_t u;
		j_view_t j;
	} instr_word_u;

endpackage

/* source/imm_gen.sv */
module imm_gen #(
	parameter int PC_W = riscv_decode_pkg::PC_W_DEFAULT
) (
	input  riscv_decode_pkg::instr_word_u        i_instr,
	input  logic [PC_W-1:0]                      i_pc,
	output logic [PC_W-1:0]                      o_imm,
	output logic [riscv_decode_pkg::SHAMT_W-1:0] o_shamt
);
	import riscv_decode_pkg::*;

	logic [PC_W-1:0]    imm_i;
	logic [PC_W-1:0]    imm_s;
	logic [PC_W-1:0]    imm_b;
	logic [PC_W-1:0]    imm_u;
	logic [PC_W-1:0]    imm_j;
	logic [SHAMT_W-1:0] shamt_raw;
	logic               is_shift;

	// sign-extended immediates of each format
	assign imm_i = {{(PC_W-12){i_instr.i.imm_11_0[11]}}, i_instr.i.imm_11_0};
	assign imm_s = {{(PC_W-12){i_instr.s.imm_11_5[6]}}, i_instr.s.imm_11_5, i_instr.s.imm_4_0};
	assign imm_b = {{(PC_W-12){i_instr.b.imm_12}}, i_instr.b.imm_11, i_instr.b.imm_10_5,
		i_instr.b.imm_4_1, 1'b0};
	assign imm_u = {{(PC_W-32){i_instr.u.imm_31_12[19]}}, i_instr.u.imm_31_12, 12'b0};
	assign imm_j = {{(PC_W-20){i_instr.j.imm_20}}, i_instr.j.imm_19_12, i_instr.j.imm_11,
		i_instr.j.imm_10_1, 1'b0};

	// slli/srli/srai and their W forms
	assign shamt_raw = i_instr.i.imm_11_0[SHAMT_W-1:0];
	assign is_shift  = (i_instr.i.funct3 == 3'b001) || (i_instr.i.funct3 == 3'b101);

	always_comb begin
		o_imm   = '0;
		o_shamt = '0;
		case (i_instr.r.opcode)
			OPC_LUI:              o_imm = imm_u;
			OPC_AUIPC:            o_imm = imm_u + i_pc;
			OPC_JAL:              o_imm = imm_j + i_pc;
			OPC_BRANCH:           o_imm = imm_b + i_pc;
			OPC_JALR, OPC_LOAD:   o_imm = imm_i;
			OPC_STORE:            o_imm = imm_s;
			OPC_OP_IMM: begin
				o_imm = imm_i;
				if (is_shift) begin
					o_shamt = shamt_raw;
					o_imm   = {{(PC_W-SHAMT_W){1'b0}}, shamt_raw};
				end
			end
			OPC_OP_IMM_32: begin
				o_imm = imm_i;
				if (is_shift) begin
					// word shifts only reach 31
					o_shamt = {1'b0, shamt_raw[SHAMT_W-2:0]};
					o_imm   = {{(PC_W-SHAMT_W+1){1'b0}}, shamt_raw[SHAMT_W-2:0]};
				end
			end
			default: ;
		endcase
	end

	always_comb begin
		assert final ((i_instr.r.opcode != OPC_SYSTEM) || (o_imm == '0))
			else $error("imm_gen: nonzero immediate on a SYSTEM word");
	end

endmodule

/* source/alu_op_decode.sv */
module alu_op_decode (
	input  riscv_decode_pkg::instr_word_u         i_instr,
	output logic [riscv_decode_pkg::ALU_OP_W-1:0] o_alu_op,
	output logic                                  o_is_word,
	output logic                                  o_func_illegal
);
	import riscv_decode_pkg::*;

	logic [2:0] funct3;
	logic [6:0] funct7;

	assign funct3 = i_instr.r.funct3;
	assign funct7 = i_instr.r.funct7;

	always_comb begin
		o_alu_op       = ALU_NONE;
		o_is_word      = 1'b0;
		o_func_illegal = 1'b0;
		case (i_instr.r.opcode)
			OPC_OP: begin
				case (funct7)
					7'b0000000: begin
						case (funct3)
							3'b000:  o_alu_op = ALU_ADD;
							3'b001:  o_alu_op = ALU_SLL;
							3'b010:  o_alu_op = ALU_LESS;
							3'b011:  o_alu_op = ALU_LESSU;
							3'b100:  o_alu_op = ALU_XOR;
							3'b101:  o_alu_op = ALU_SRL;
							3'b110:  o_alu_op = ALU_OR;
							default: o_alu_op = ALU_AND;
						endcase
					end
					7'b0100000: begin
						case (funct3)
							3'b000:  o_alu_op = ALU_SUB;
							3'b101:  o_alu_op = ALU_SRA;
							default: o_func_illegal = 1'b1;
						endcase
					end
					// M extension
					7'b0000001: begin
						case (funct3)
							3'b000:  o_alu_op = ALU_MUL;
							3'b001:  o_alu_op = ALU_MULH;
							3'b010:  o_alu_op = ALU_MULHSU;
							3'b011:  o_alu_op = ALU_MULHU;
							3'b100:  o_alu_op = ALU_DIV;
							3'b101:  o_alu_op = ALU_DIVU;
							3'b110:  o_alu_op = ALU_REM;
							default: o_alu_op = ALU_REMU;
						endcase
					end
					default: o_func_illegal = 1'b1;
				endcase
			end
			OPC_OP_32: begin
				o_is_word = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: o_alu_op = ALU_ADD;
					{7'b0000000, 3'b001}: o_alu_op = ALU_SLL;
					{7'b0000000, 3'b101}: o_alu_op = ALU_SRL;
					{7'b0100000, 3'b000}: o_alu_op = ALU_SUB;
					{7'b0100000, 3'b101}: o_alu_op = ALU_SRA;
					{7'b0000001, 3'b000}: o_alu_op = ALU_MUL;
					{7'b0000001, 3'b100}: o_alu_op = ALU_DIV;
					{7'b0000001, 3'b101}: o_alu_op = ALU_DIVU;
					{7'b0000001, 3'b110}: o_alu_op = ALU_REM;
					{7'b0000001, 3'b111}: o_alu_op = ALU_REMU;
					default:              o_func_illegal = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				// funct7[0] is shamt[5] here so only six bits select the shift
				case (funct3)
					3'b000: o_alu_op = ALU_ADD;
					3'b010: o_alu_op = ALU_LESS;
					3'b011: o_alu_op = ALU_LESSU;
					3'b100: o_alu_op = ALU_XOR;
					3'b110: o_alu_op = ALU_OR;
					3'b111: o_alu_op = ALU_AND;
					3'b001: begin
						if (funct7[6:1] == 6'b000000)
							o_alu_op = ALU_SLL;
						else
							o_func_illegal = 1'b1;
					end
					default: begin
						if (funct7[6:1] == 6'b000000)
							o_alu_op = ALU_SRL;
						else if (funct7[6:1] == 6'b010000)
							o_alu_op = ALU_SRA;
						else
							o_func_illegal = 1'b1;
					end
				endcase
			end
			OPC_OP_IMM_32: begin
				o_is_word = 1'b1;
				case ({funct3, funct7})
					{3'b001, 7'b0000000}: o_alu_op = ALU_SLL;
					{3'b101, 7'b0000000}: o_alu_op = ALU_SRL;
					{3'b101, 7'b0100000}: o_alu_op = ALU_SRA;
					default: begin
						if (funct3 == 3'b000)
							o_alu_op = ALU_ADD;
						else
							o_func_illegal = 1'b1;
					end
				endcase
			end
			OPC_BRANCH: begin
				case (funct3)
					3'b000:  o_alu_op = ALU_EQUAL;
					3'b001:  o_alu_op = ALU_NEQ;
					3'b100:  o_alu_op = ALU_LESS;
					3'b101:  o_alu_op = ALU_GTE;
					3'b110:  o_alu_op = ALU_LESSU;
					3'b111:  o_alu_op = ALU_GTEU;
					default: o_func_illegal = 1'b1;
				endcase
			end
			// address generation uses the adder
			OPC_LOAD, OPC_STORE, OPC_JALR: o_alu_op = ALU_ADD;
			OPC_JAL:                       o_alu_op = ALU_JUMP;
			OPC_LUI, OPC_AUIPC:            o_alu_op = ALU_IMMVAL;
			default: ;
		endcase
	end

	always_comb begin
		assert final (!o_func_illegal || (o_alu_op == ALU_NONE))
			else $error("alu_op_decode: illegal function carries an ALU code");
	end

endmodule

/* source/control_decode.sv */
module control_decode (
	input  riscv_decode_pkg::instr_word_u i_instr,
	output logic [2:0]                    o_fmt,
	output logic                          o_reg_write,
	output logic [1:0]                    o_mem_access,
	output logic [2:0]                    o_mem_size,
	output logic [1:0]                    o_branch,
	output logic                          o_ecall,
	output logic                          o_op_illegal
);
	import riscv_decode_pkg::*;

	logic [2:0] funct3;

	assign funct3 = i_instr.r.funct3;

	always_comb begin
		o_fmt        = FMT_NONE;
		o_reg_write  = 1'b0;
		o_mem_access = MEM_NONE;
		o_mem_size   = SIZE_NONE;
		o_branch     = BR_NONE;
		o_ecall      = 1'b0;
		o_op_illegal = 1'b0;
		case (i_instr.r.opcode)
			OPC_LUI, OPC_AUIPC: begin
				o_fmt       = FMT_U;
				o_reg_write = 1'b1;
			end
			// both jumps write the link address
			OPC_JAL: begin
				o_fmt       = FMT_UJ;
				o_reg_write = 1'b1;
				o_branch    = BR_UNCOND;
			end
			OPC_JALR: begin
				o_fmt       = FMT_I;
				o_reg_write = 1'b1;
				o_branch    = BR_UNCOND;
			end
			OPC_BRANCH: begin
				o_fmt    = FMT_SB;
				o_branch = BR_COND;
			end
			OPC_LOAD: begin
				o_fmt        = FMT_I;
				o_reg_write  = 1'b1;
				o_mem_access = MEM_READ;
				case (funct3)
					3'b000: o_mem_size = SIZE_BYTE;
					3'b001: o_mem_size = SIZE_HALF;
					3'b010: o_mem_size = SIZE_WORD;
					3'b011: o_mem_size = SIZE_DOUBLE;
					3'b100: o_mem_size = SIZE_UBYTE;
					3'b101: o_mem_size = SIZE_UHALF;
					3'b110: o_mem_size = SIZE_UWORD;
					default: begin
						o_mem_access = MEM_NONE;
						o_op_illegal = 1'b1;
					end
				endcase
			end
			OPC_STORE: begin
				o_fmt        = FMT_S;
				o_mem_access = MEM_WRITE;
				case (funct3)
					3'b000: o_mem_size = SIZE_BYTE;
					3'b001: o_mem_size = SIZE_HALF;
					3'b010: o_mem_size = SIZE_WORD;
					3'b011: o_mem_size = SIZE_DOUBLE;
					default: begin
						o_mem_access = MEM_NONE;
						o_op_illegal = 1'b1;
					end
				endcase
			end
			OPC_OP_IMM, OPC_OP_IMM_32: begin
				o_fmt       = FMT_I;
				o_reg_write = 1'b1;
			end
			OPC_OP, OPC_OP_32: begin
				o_fmt       = FMT_R;
				o_reg_write = 1'b1;
			end
			OPC_SYSTEM: begin
				// ebreak, csr and fence variants are not supported
				if (i_instr == ECALL_WORD)
					o_ecall = 1'b1;
				else
					o_op_illegal = 1'b1;
			end
			default: o_op_illegal = 1'b1;
		endcase
	end

	always_comb begin
		assert final (!o_ecall || !o_reg_write)
			else $error("control_decode: ecall requests a register write");
		assert final ((o_mem_access != MEM_WRITE) || (o_fmt == FMT_S))
			else $error("control_decode: memory write outside the S format");
	end

endmodule

/* source/riscv_decoder.sv */
module riscv_decoder #(
	parameter int PC_W = riscv_decode_pkg::PC_W_DEFAULT
) (
	input  logic                                   clk,
	input  logic                                   i_rst,
	input  logic [riscv_decode_pkg::INSTR_W-1:0]   i_instr,
	input  logic [PC_W-1:0]                        i_pc,
	output logic [riscv_decode_pkg::REG_IDX_W-1:0] o_rd,
	output logic [riscv_decode_pkg::REG_IDX_W-1:0] o_rs1,
	output logic [riscv_decode_pkg::REG_IDX_W-1:0] o_rs2,
	output logic [PC_W-1:0]                        o_imm,
	output logic [riscv_decode_pkg::SHAMT_W-1:0]   o_shamt,
	output logic [riscv_decode_pkg::ALU_OP_W-1:0]  o_alu_op,
	output logic [2:0]                             o_fmt,
	output logic                                   o_reg_write,
	output logic [1:0]                             o_mem_access,
	output logic [2:0]                             o_mem_size,
	output logic [1:0]                             o_branch,
	output logic                                   o_is_word,
	output logic                                   o_ecall,
	output logic                                   o_illegal
);
	import riscv_decode_pkg::*;

	instr_word_u         instr;
	logic [PC_W-1:0]     imm;
	logic [SHAMT_W-1:0]  shamt;
	logic [ALU_OP_W-1:0] alu_op;
	logic                is_word;
	logic                func_illegal;
	logic [2:0]          fmt;
	logic                reg_write;
	logic [1:0]          mem_access;
	logic [2:0]          mem_size;
	logic [1:0]          branch;
	logic                ecall;
	logic                op_illegal;
	logic                illegal;

	assign instr   = i_instr;
	assign illegal = func_illegal | op_illegal;

	imm_gen #(
		.PC_W (PC_W)
	) u_imm_gen (
		.i_instr (instr),
		.i_pc    (i_pc),
		.o_imm   (imm),
		.o_shamt (shamt)
	);

	alu_op_decode u_alu_op_decode (
		.i_instr        (instr),
		.o_alu_op       (alu_op),
		.o_is_word      (is_word),
		.o_func_illegal (func_illegal)
	);

	control_decode u_control_decode (
		.i_instr      (instr),
		.o_fmt        (fmt),
		.o_reg_write  (reg_write),
		.o_mem_access (mem_access),
		.o_mem_size   (mem_size),
		.o_branch     (branch),
		.o_ecall      (ecall),
		.o_op_illegal (op_illegal)
	);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_rd         <= '0;
			o_rs1        <= '0;
			o_rs2        <= '0;
			o_imm        <= '0;
			o_shamt      <= '0;
			o_alu_op     <= ALU_NONE;
			o_fmt        <= FMT_NONE;
			o_reg_write  <= 1'b0;
			o_mem_access <= MEM_NONE;
			o_mem_size   <= SIZE_NONE;
			o_branch     <= BR_NONE;
			o_is_word    <= 1'b0;
			o_ecall      <= 1'b0;
			o_illegal    <= 1'b0;
		end else begin
			o_rd      <= instr.r.rd;
			o_rs1     <= instr.r.rs1;
			o_rs2     <= instr.r.rs2;
			o_imm     <= imm;
			o_shamt   <= shamt;
			o_illegal <= illegal;
			// an illegal word leaves only the flag and the raw fields
			o_alu_op     <= illegal ? ALU_NONE : alu_op;
			o_fmt        <= illegal ? FMT_NONE : fmt;
			o_reg_write  <= reg_write & ~illegal;
			o_mem_access <= illegal ? MEM_NONE : mem_access;
			o_mem_size   <= illegal ? SIZE_NONE : mem_size;
			o_branch     <= illegal ? BR_NONE : branch;
			o_is_word    <= is_word & ~illegal;
			o_ecall      <= ecall & ~illegal;
		end
	end

	a_illegal_quiet: assert property (@(posedge clk) disable iff (i_rst)
		o_illegal |-> (!o_reg_write && (o_mem_access == MEM_NONE)))
		else $error("riscv_decoder: illegal word reached a write or memory access");

endmodule

/* verification/decoder_vectors.svh */
`ifndef DECODER_VECTORS_SVH
`define DECODER_VECTORS_SVH

// columns: name, instruction word, immediate mode, immediate before sign extension
// and PC add, then alu op, format, memory access, memory size, branch kind, and
// flags {reg_write, is_word, ecall, illegal}
task automatic load_vectors();
	// register-register, rd x1, rs1 x2, rs2 x3
	add_vector("add", 32'h003100B3, IMM_RAW, 32'h0,
		ALU_ADD, FMT_R, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1000);
	add_vector("sub", 32'h403100B3, IMM_RAW, 32'h0,
		ALU_SUB, FMT_R, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1000);
	add_vector("sra", 32'h403150B3, IMM_RAW, 32'h0,
		ALU_SRA, FMT_R, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1000);
	add_vector("mulhsu", 32'h023120B3, IMM_RAW, 32'h0,
		ALU_MULHSU, FMT_R, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1000);
	add_vector("remu", 32'h023170B3, IMM_RAW, 32'h0,
		ALU_REMU, FMT_R, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1000);
	add_vector("addw", 32'h003100BB, IMM_RAW, 32'h0,
		ALU_ADD, FMT_R, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1100);
	add_vector("mulw", 32'h023100BB, IMM_RAW, 32'h0,
		ALU_MUL, FMT_R, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1100);
	add_vector("divuw", 32'h023150BB, IMM_RAW, 32'h0,
		ALU_DIVU, FMT_R, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1100);
	// funct7 0010000 is not an OP-32 encoding
	add_vector("op32_bad_funct7", 32'h203100BB, IMM_RAW, 32'h0,
		ALU_NONE, FMT_NONE, MEM_NONE, SIZE_NONE, BR_NONE, 4'b0001);

	// immediates and shifts
	add_vector("addi", 32'hFFB10093, IMM_RAW, 32'hFFFFFFFB,
		ALU_ADD, FMT_I, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1000);
	add_vector("sltiu", 32'h00113093, IMM_RAW, 32'h1,
		ALU_LESSU, FMT_I, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1000);
	add_vector("slli", 32'h02D11093, IMM_SH, 32'h2D,
		ALU_SLL, FMT_I, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1000);
	add_vector("srai", 32'h43F15093, IMM_SH, 32'h3F,
		ALU_SRA, FMT_I, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1000);
	add_vector("addiw", 32'hFFF1009B, IMM_RAW, 32'hFFFFFFFF,
		ALU_ADD, FMT_I, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1100);
	add_vector("sraiw", 32'h41F1509B, IMM_SH, 32'h1F,
		ALU_SRA, FMT_I, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1100);
	// shamt 33 on a word shift, the upper bit is dropped and the word is illegal
	add_vector("slliw_shamt5", 32'h0211109B, IMM_SH, 32'h1,
		ALU_NONE, FMT_NONE, MEM_NONE, SIZE_NONE, BR_NONE, 4'b0001);
	add_vector("lui", 32'h800000B7, IMM_RAW, 32'h80000000,
		ALU_IMMVAL, FMT_U, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1000);
	add_vector("auipc", 32'h12345097, IMM_PC, 32'h12345000,
		ALU_IMMVAL, FMT_U, MEM_NONE, SIZE_NONE, BR_NONE, 4'b1000);

	// jumps and branches
	add_vector("jal", 32'hFFDFF0EF, IMM_PC, 32'hFFFFFFFC,
		ALU_JUMP, FMT_UJ, MEM_NONE, SIZE_NONE, BR_UNCOND, 4'b1000);
	add_vector("jalr", 32'h010100E7, IMM_RAW, 32'h10,
		ALU_ADD, FMT_I, MEM_NONE, SIZE_NONE, BR_UNCOND, 4'b1000);
	add_vector("beq", 32'h00310863, IMM_PC, 32'h10,
		ALU_EQUAL, FMT_SB, MEM_NONE, SIZE_NONE, BR_COND, 4'b0000);
	add_vector("bne", 32'hFE311FE3, IMM_PC, 32'hFFFFFFFE,
		ALU_NEQ, FMT_SB, MEM_NONE, SIZE_NONE, BR_COND, 4'b0000);
	add_vector("blt", 32'h00314463, IMM_PC, 32'h8,
		ALU_LESS, FMT_SB, MEM_NONE, SIZE_NONE, BR_COND, 4'b0000);
	add_vector("bge", 32'h00315463, IMM_PC, 32'h8,
		ALU_GTE, FMT_SB, MEM_NONE, SIZE_NONE, BR_COND, 4'b0000);
	add_vector("bltu", 32'h00316463, IMM_PC, 32'h8,
		ALU_LESSU, FMT_SB, MEM_NONE, SIZE_NONE, BR_COND, 4'b0000);
	add_vector("bgeu", 32'h00317463, IMM_PC, 32'h8,
		ALU_GTEU, FMT_SB, MEM_NONE, SIZE_NONE, BR_COND, 4'b0000);
	add_vector("branch_f3_010", 32'h00312463, IMM_PC, 32'h8,
		ALU_NONE, FMT_NONE, MEM_NONE, SIZE_NONE, BR_NONE, 4'b0001);

	// loads and stores
	add_vector("lb", 32'hFFF10083, IMM_RAW, 32'hFFFFFFFF,
		ALU_ADD, FMT_I, MEM_READ, SIZE_BYTE, BR_NONE, 4'b1000);
	add_vector("lh", 32'h00211083, IMM_RAW, 32'h2,
		ALU_ADD, FMT_I, MEM_READ, SIZE_HALF, BR_NONE, 4'b1000);
	add_vector("lw", 32'h00012083, IMM_RAW, 32'h0,
		ALU_ADD, FMT_I, MEM_READ, SIZE_WORD, BR_NONE, 4'b1000);
	add_vector("ld", 32'h00813083, IMM_RAW, 32'h8,
		ALU_ADD, FMT_I, MEM_READ, SIZE_DOUBLE, BR_NONE, 4'b1000);
	add_vector("lbu", 32'h00014083, IMM_RAW, 32'h0,
		ALU_ADD, FMT_I, MEM_READ, SIZE_UBYTE, BR_NONE, 4'b1000);
	add_vector("lhu", 32'h00015083, IMM_RAW, 32'h0,
		ALU_ADD, FMT_I, MEM_READ, SIZE_UHALF, BR_NONE, 4'b1000);
	add_vector("lwu", 32'h00016083, IMM_RAW, 32'h0,
		ALU_ADD, FMT_I, MEM_READ, SIZE_UWORD, BR_NONE, 4'b1000);
	add_vector("load_f3_111", 32'h00017083, IMM_RAW, 32'h0,
		ALU_NONE, FMT_NONE, MEM_NONE, SIZE_NONE, BR_NONE, 4'b0001);
	add_vector("sb", 32'hFE310C23, IMM_RAW, 32'hFFFFFFF8,
		ALU_ADD, FMT_S, MEM_WRITE, SIZE_BYTE, BR_NONE, 4'b0000);
	add_vector("sh", 32'h00311223, IMM_RAW, 32'h4,
		ALU_ADD, FMT_S, MEM_WRITE, SIZE_HALF, BR_NONE, 4'b0000);
	add_vector("sw", 32'h7E312FA3, IMM_RAW, 32'h7FF,
		ALU_ADD, FMT_S, MEM_WRITE, SIZE_WORD, BR_NONE, 4'b0000);
	add_vector("sd", 32'h00313823, IMM_RAW, 32'h10,
		ALU_ADD, FMT_S, MEM_WRITE, SIZE_DOUBLE, BR_NONE, 4'b0000);

	// system and unknown opcodes
	add_vector("ecall", 32'h00000073, IMM_RAW, 32'h0,
		ALU_NONE, FMT_NONE, MEM_NONE, SIZE_NONE, BR_NONE, 4'b0010);
	add_vector("ebreak", 32'h00100073, IMM_RAW, 32'h0,
		ALU_NONE, FMT_NONE, MEM_NONE, SIZE_NONE, BR_NONE, 4'b0001);
	add_vector("custom0", 32'h0031008B, IMM_RAW, 32'h0,
		ALU_NONE, FMT_NONE, MEM_NONE, SIZE_NONE, BR_NONE, 4'b0001);
endtask

`endif

/* verification/decoder_tb.sv */
module decoder_tb;
	import riscv_decode_pkg::*;

	localparam int PC_W      = PC_W_DEFAULT;
	localparam int RST_LIMIT = 32;

	// how the expected immediate is formed from the table value
	localparam logic [1:0] IMM_RAW = 2'd0;
	localparam logic [1:0] IMM_PC  = 2'd1;
	localparam logic [1:0] IMM_SH  = 2'd2;

	logic                 clk;
	logic                 i_rst;
	logic [INSTR_W-1:0]   i_instr;
	logic [PC_W-1:0]      i_pc;
	logic [REG_IDX_W-1:0] o_rd;
	logic [REG_IDX_W-1:0] o_rs1;
	logic [REG_IDX_W-1:0] o_rs2;
	logic [PC_W-1:0]      o_imm;
	logic [SHAMT_W-1:0]   o_shamt;
	logic [ALU_OP_W-1:0]  o_alu_op;
	logic [2:0]           o_fmt;
	logic                 o_reg_write;
	logic [1:0]           o_mem_access;
	logic [2:0]           o_mem_size;
	logic [1:0]           o_branch;
	logic                 o_is_word;
	logic                 o_ecall;
	logic                 o_illegal;

	string               vec_name  [$];
	logic [31:0]         vec_instr [$];
	logic [1:0]          vec_mode  [$];
	logic [31:0]         vec_imm   [$];
	logic [ALU_OP_W-1:0] vec_alu   [$];
	logic [2:0]          vec_fmt   [$];
	logic [1:0]          vec_mem   [$];
	logic [2:0]          vec_size  [$];
	logic [1:0]          vec_br    [$];
	logic [3:0]          vec_flags [$];
	logic [PC_W-1:0]     vec_pc    [$];

	int     pass_count;
	int     fail_count;
	int     test_errors;
	integer seed = 56796;

	riscv_decoder u_riscv_decoder (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_instr      (i_instr),
		.i_pc         (i_pc),
		.o_rd         (o_rd),
		.o_rs1        (o_rs1),
		.o_rs2        (o_rs2),
		.o_imm        (o_imm),
		.o_shamt      (o_shamt),
		.o_alu_op     (o_alu_op),
		.o_fmt        (o_fmt),
		.o_reg_write  (o_reg_write),
		.o_mem_access (o_mem_access),
		.o_mem_size   (o_mem_size),
		.o_branch     (o_branch),
		.o_is_word    (o_is_word),
		.o_ecall      (o_ecall),
		.o_illegal    (o_illegal)
	);

	always #2 clk = ~clk;

	task automatic add_vector(input string name, input logic [31:0] instr,
		input logic [1:0] mode, input logic [31:0] imm, input logic [ALU_OP_W-1:0] alu,
		input logic [2:0] fmt, input logic [1:0] mem, input logic [2:0] size,
		input logic [1:0] br, input logic [3:0] flags);
		vec_name.push_back(name);
		vec_instr.push_back(instr);
		vec_mode.push_back(mode);
		vec_imm.push_back(imm);
		vec_alu.push_back(alu);
		vec_fmt.push_back(fmt);
		vec_mem.push_back(mem);
		vec_size.push_back(size);
		vec_br.push_back(br);
		vec_flags.push_back(flags);
	endtask

	`include "decoder_vectors.svh"

	task automatic compare_field(input string name, input string field,
		input logic [63:0] exp_val, input logic [63:0] act_val);
		if (act_val !== exp_val) begin
			$display("** Error at %0t: %s %s expected %0h got %0h",
				$time, name, field, exp_val, act_val);
			test_errors++;
		end
	endtask

	task automatic check_outputs(input string name, input logic [PC_W-1:0] e_imm,
		input logic [SHAMT_W-1:0] e_shamt, input logic [ALU_OP_W-1:0] e_alu,
		input logic [2:0] e_fmt, input logic e_rw, input logic [1:0] e_mem,
		input logic [2:0] e_size, input logic [1:0] e_br, input logic e_word,
		input logic e_ecall, input logic e_ill, input logic [REG_IDX_W-1:0] e_rd,
		input logic [REG_IDX_W-1:0] e_rs1, input logic [REG_IDX_W-1:0] e_rs2);
		compare_field(name, "imm", 64'(e_imm), 64'(o_imm));
		compare_field(name, "shamt", 64'(e_shamt), 64'(o_shamt));
		compare_field(name, "alu_op", 64'(e_alu), 64'(o_alu_op));
		compare_field(name, "fmt", 64'(e_fmt), 64'(o_fmt));
		compare_field(name, "reg_write", 64'(e_rw), 64'(o_reg_write));
		compare_field(name, "mem_access", 64'(e_mem), 64'(o_mem_access));
		compare_field(name, "mem_size", 64'(e_size), 64'(o_mem_size));
		compare_field(name, "branch", 64'(e_br), 64'(o_branch));
		compare_field(name, "is_word", 64'(e_word), 64'(o_is_word));
		compare_field(name, "ecall", 64'(e_ecall), 64'(o_ecall));
		compare_field(name, "illegal", 64'(e_ill), 64'(o_illegal));
		compare_field(name, "rd", 64'(e_rd), 64'(o_rd));
		compare_field(name, "rs1", 64'(e_rs1), 64'(o_rs1));
		compare_field(name, "rs2", 64'(e_rs2), 64'(o_rs2));
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("test %s ok", name);
		end else begin
			fail_count++;
			$display("test %s failed with %0d mismatches", name, test_errors);
		end
		test_errors = 0;
	endtask

	// expected values come from the table entry and the PC it was driven with
	task automatic check_vector(input int idx);
		logic [PC_W-1:0]    exp_imm;
		logic [SHAMT_W-1:0] exp_shamt;
		logic [31:0]        raw;
		logic [31:0]        word;
		logic [3:0]         flags;
		raw       = vec_imm[idx];
		word      = vec_instr[idx];
		flags     = vec_flags[idx];
		exp_imm   = {{(PC_W-32){raw[31]}}, raw};
		exp_shamt = '0;
		if (vec_mode[idx] == IMM_PC)
			exp_imm = exp_imm + vec_pc[idx];
		if (vec_mode[idx] == IMM_SH)
			exp_shamt = raw[SHAMT_W-1:0];
		check_outputs(vec_name[idx], exp_imm, exp_shamt, vec_alu[idx], vec_fmt[idx],
			flags[3], vec_mem[idx], vec_size[idx], vec_br[idx], flags[2], flags[1],
			flags[0], word[11:7], word[19:15], word[24:20]);
		finish_test(vec_name[idx]);
	endtask

	// reset held for 8 rising edges and released on a falling edge
	initial begin
		i_rst = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		i_rst <= 1'b0;
	end

	initial begin
		int              k;
		int              cycles;
		logic            timed_out;
		logic [PC_W-1:0] pc_now;
		clk         = 1'b0;
		i_instr     = 32'h003100B3;
		i_pc        = '0;
		pass_count  = 0;
		fail_count  = 0;
		test_errors = 0;
		cycles      = 0;
		timed_out   = 1'b0;
		load_vectors();

		// a writing word sits on the input so reset has to mask it
		@(negedge clk);
		while (i_rst && !timed_out) begin
			check_outputs("reset", '0, '0, ALU_NONE, FMT_NONE, 1'b0, MEM_NONE, SIZE_NONE,
				BR_NONE, 1'b0, 1'b0, 1'b0, '0, '0, '0);
			cycles++;
			if (cycles > RST_LIMIT)
				timed_out = 1'b1;
			else
				@(negedge clk);
		end

		if (timed_out) begin
			$display("timeout: reset was not released within %0d cycles", RST_LIMIT);
			$display("=== FAIL ===");
		end else begin
			finish_test("reset");

			// entry k goes in on one falling edge and is checked on the next
			for (k = 0; k <= vec_name.size(); k++) begin
				if (k > 0)
					check_vector(k - 1);
				if (k < vec_name.size()) begin
					pc_now = {$random(seed), $random(seed)};
					vec_pc.push_back(pc_now);
					i_instr = vec_instr[k];
					i_pc    = pc_now;
					@(negedge clk);
				end
			end

			$display("tests passed %0d, failed %0d", pass_count, fail_count);
			if (fail_count == 0) begin
				$display("=== PASS ===");
			end else begin
				$display("=== FAIL ===");
			end
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+verification
source/riscv_decode_pkg.sv
source/imm_gen.sv
source/alu_op_decode.sv
source/control_decode.sv
source/riscv_decoder.sv
verification/decoder_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the decoder testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --timing --assert -j 0 --Mdir "$build_dir" \
	--top-module decoder_tb -o decoder_sim -f src.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

"./$build_dir/decoder_sim" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "=== FAIL ===" "$log"; then
	echo "simulation reported failures, see $log"
	exit 1
fi
exit 0
